// File: source/boot_pkg.sv
package boot_pkg;

  // one received byte with its strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  // one instruction memory write
  typedef struct packed {
    logic        we;
    logic [11:0] addr;
    logic [31:0] wdata;
  } imem_wr_t;

  // fetch port, word addressed
  typedef struct packed {
    logic        req;
    logic [11:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } fetch_rsp_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    CTRL_COLLECT,
    CTRL_WRITE,
    CTRL_DONE
  } ctrl_state_e;

  // last word of a boot image, never stored
  localparam logic [31:0] BOOT_END_WORD = 32'h0000_0FFF;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import boot_pkg::*; #(
  parameter int CLKS_PER_BIT = 87
) (
  input  logic     clock,
  input  logic     reset_i,
  input  logic     rx_serial_i,
  output rx_byte_t rx_byte_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             rx_prev_q;
  rx_state_e        state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             valid_q;

  // two flop synchronizer, idles high like the line
  always_ff @(posedge clock) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge starts a frame
          if (rx_prev_q && !rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt_q == HALF_BIT) begin
            clk_cnt_q <= '0;
            // glitch shorter than half a bit
            if (rx_sync_q) begin
              state_q <= RX_IDLE;
            end else begin
              state_q <= RX_DATA;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (clk_cnt_q == BIT_LAST) begin
            clk_cnt_q <= '0;
            state_q   <= RX_IDLE;
            // low stop bit means framing error, byte dropped
            valid_q   <= rx_sync_q;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clock) begin
    if (state_q == RX_DATA && clk_cnt_q == BIT_LAST) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte_o = '{valid: valid_q, data: shift_q};

endmodule

// File: source/iccm_controller.sv
`timescale 1ns/1ps

module iccm_controller import boot_pkg::*; #(
  parameter int IMEM_AW = 12
) (
  input  logic     clock,
  input  logic     reset_i,
  input  rx_byte_t rx_byte_i,
  output imem_wr_t imem_wr_o,
  output logic     core_reset_o
);

  ctrl_state_e        state_q;
  logic [1:0]         byte_cnt_q;
  logic [31:0]        word_q;
  logic [31:0]        word_next;
  logic [IMEM_AW-1:0] addr_q;
  logic               core_reset_q;
  logic               byte_take;

  // bytes are ignored once the image is complete
  assign byte_take = rx_byte_i.valid && (state_q != CTRL_DONE);

  // newest byte enters at the top, so byte 0 ends up in bits 7:0
  assign word_next = {rx_byte_i.data, word_q[31:8]};

  always_ff @(posedge clock) begin
    if (byte_take) begin
      word_q <= word_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q      <= CTRL_COLLECT;
      byte_cnt_q   <= '0;
      addr_q       <= '0;
      core_reset_q <= 1'b1;
    end else begin
      if (byte_take) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      case (state_q)
        CTRL_COLLECT: begin
          if (byte_take && byte_cnt_q == 2'd3) begin
            if (word_next == BOOT_END_WORD) begin
              // terminator releases the core, no write
              state_q      <= CTRL_DONE;
              core_reset_q <= 1'b0;
            end else begin
              state_q <= CTRL_WRITE;
            end
          end
        end
        CTRL_WRITE: begin
          // single write cycle, then next word address
          addr_q  <= addr_q + 1'b1;
          state_q <= CTRL_COLLECT;
        end
        CTRL_DONE: begin
          state_q <= CTRL_DONE;
        end
        default: begin
          state_q <= CTRL_COLLECT;
        end
      endcase
    end
  end

  assign imem_wr_o = '{
    we:    (state_q == CTRL_WRITE),
    addr:  12'(addr_q),
    wdata: word_q
  };

  assign core_reset_o = core_reset_q;

endmodule

// File: source/instr_mem.sv
`timescale 1ns/1ps

module instr_mem import boot_pkg::*; #(
  parameter int IMEM_AW = 12
) (
  input  logic       clock,
  input  imem_wr_t   wr_i,
  input  fetch_req_t fetch_req_i,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       reset_i
);

  logic [31:0] mem [2**IMEM_AW];
  logic [31:0] rdata_q;
  logic        rvalid_q;

  always_ff @(posedge clock) begin
    if (wr_i.we) begin
      mem[wr_i.addr[IMEM_AW-1:0]] <= wr_i.wdata;
    end
  end

  // read sees the old word on a same cycle write
  always_ff @(posedge clock) begin
    if (fetch_req_i.req) begin
      rdata_q <= mem[fetch_req_i.addr[IMEM_AW-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= fetch_req_i.req;
    end
  end

  assign fetch_rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

// File: source/iccm_boot_top.sv
`timescale 1ns/1ps

module iccm_boot_top import boot_pkg::*; #(
  parameter int CLKS_PER_BIT = 87,
  parameter int IMEM_AW      = 12
) (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       uart_rx_i,
  input  fetch_req_t fetch_req_i,
  output fetch_rsp_t fetch_rsp_o,
  output logic       core_reset_o
);

  rx_byte_t rx_byte;
  imem_wr_t imem_wr;

  // serial programmer
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clock       (clock),
    .reset_i     (reset_i),
    .rx_serial_i (uart_rx_i),
    .rx_byte_o   (rx_byte)
  );

  // word assembly and core reset hold
  iccm_controller #(
    .IMEM_AW (IMEM_AW)
  ) u_iccm_controller (
    .clock        (clock),
    .reset_i      (reset_i),
    .rx_byte_i    (rx_byte),
    .imem_wr_o    (imem_wr),
    .core_reset_o (core_reset_o)
  );

  // iccm, fetch port goes straight out
  instr_mem #(
    .IMEM_AW (IMEM_AW)
  ) u_instr_mem (
    .clock       (clock),
    .wr_i        (imem_wr),
    .fetch_req_i (fetch_req_i),
    .fetch_rsp_o (fetch_rsp_o),
    .reset_i     (reset_i)
  );

endmodule

// File: testbench/iccm_boot_assertions.sv
`timescale 1ns/1ps

module iccm_boot_assertions import boot_pkg::*; (
  input logic        clock,
  input logic        reset_i,
  input ctrl_state_e state_i,
  input imem_wr_t    wr_i,
  input logic        core_reset_i
);

  logic [11:0] last_addr_q;
  logic        have_prev_q;

  // address of the previous write since reset
  always_ff @(posedge clock) begin
    if (reset_i) begin
      have_prev_q <= 1'b0;
      last_addr_q <= '0;
    end else if (wr_i.we) begin
      have_prev_q <= 1'b1;
      last_addr_q <= wr_i.addr;
    end
  end

  core_reset_rise_on_reset: assert property (
    @(posedge clock) $rose(core_reset_i) |-> $past(reset_i)
  ) else $error("core reset rose without reset");

  single_cycle_write: assert property (
    @(posedge clock) disable iff (reset_i) wr_i.we |=> !wr_i.we
  ) else $error("write strobe held for two cycles");

  no_write_when_done: assert property (
    @(posedge clock) disable iff (reset_i) (state_i == CTRL_DONE) |=> !wr_i.we
  ) else $error("write issued after the terminator");

  first_write_at_zero: assert property (
    @(posedge clock) disable iff (reset_i) (wr_i.we && !have_prev_q) |-> (wr_i.addr == 12'd0)
  ) else $error("first write after reset not at address 0");

  write_addr_steps: assert property (
    @(posedge clock) disable iff (reset_i)
      (wr_i.we && have_prev_q) |-> (wr_i.addr == last_addr_q + 12'd1)
  ) else $error("write address did not step by one");

endmodule

// File: testbench/tb_iccm_boot.sv
`timescale 1ns/1ps

module tb_iccm_boot import boot_pkg::*; ();

  localparam int CLK_NS       = 4;
  localparam int CLKS_PER_BIT = 8;
  // well above the serial traffic of all tests together
  localparam int WATCHDOG_NS  = 400_000;

  logic        clock;
  logic        reset;
  logic        uart_rx;
  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  logic        core_reset;
  int unsigned error_count;
  int unsigned check_count;
  logic [31:0] rng_state;
  logic [31:0] sent_q [$];

  iccm_boot_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .IMEM_AW      (12)
  ) DUT (
    .clock        (clock),
    .reset_i      (reset),
    .uart_rx_i    (uart_rx),
    .fetch_req_i  (fetch_req),
    .fetch_rsp_o  (fetch_rsp),
    .core_reset_o (core_reset)
  );

  bind iccm_controller iccm_boot_assertions u_assertions (
    .clock        (clock),
    .reset_i      (reset_i),
    .state_i      (state_q),
    .wr_i         (imem_wr_o),
    .core_reset_i (core_reset_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_NS / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
    $display("TB FAILED");
    $finish;
  end

  // xorshift32, skips the terminator value
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    do begin
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
    end while (x == BOOT_END_WORD);
    rng_state = x;
    return x;
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
  endtask

  task automatic send_bit(input logic level);
    uart_rx = level;
    repeat (CLKS_PER_BIT) @(negedge clock);
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_stop);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      send_bit(data[i]);
    end
    send_bit(!bad_stop);
    // idle bit so the next start edge is seen
    send_bit(1'b1);
  endtask

  task automatic send_word(input logic [31:0] word);
    for (int i = 0; i < 4; i++) begin
      send_byte(word[8*i +: 8], 1'b0);
    end
  endtask

  task automatic load_words(input int count);
    logic [31:0] w;
    for (int i = 0; i < count; i++) begin
      w = next_rand();
      sent_q.push_back(w);
      send_word(w);
      expect_eq(32'(core_reset), 32'd1, "core reset held while loading");
    end
  endtask

  task automatic send_terminator();
    send_word(BOOT_END_WORD);
    expect_eq(32'(core_reset), 32'd0, "core reset released by terminator");
  endtask

  task automatic read_word(input logic [11:0] addr, input logic [31:0] exp);
    fetch_req = '{req: 1'b1, addr: addr};
    @(negedge clock);
    fetch_req = '{req: 1'b0, addr: 12'd0};
    expect_eq(32'(fetch_rsp.rvalid), 32'd1, $sformatf("rvalid for addr %0d", addr));
    expect_eq(fetch_rsp.rdata, exp, $sformatf("rdata at addr %0d", addr));
    @(negedge clock);
    expect_eq(32'(fetch_rsp.rvalid), 32'd0, "rvalid after single request");
  endtask

  task automatic test_reset_and_fetch();
    expect_eq(32'(core_reset), 32'd1, "core reset after reset");
    repeat (3) begin
      expect_eq(32'(fetch_rsp.rvalid), 32'd0, "rvalid idle");
      @(negedge clock);
    end
    fetch_req = '{req: 1'b1, addr: 12'd5};
    @(negedge clock);
    fetch_req = '{req: 1'b0, addr: 12'd0};
    expect_eq(32'(fetch_rsp.rvalid), 32'd1, "rvalid one cycle after request");
    @(negedge clock);
    expect_eq(32'(fetch_rsp.rvalid), 32'd0, "rvalid dropped after one cycle");
    // four requests back to back
    for (int i = 0; i < 4; i++) begin
      fetch_req = '{req: 1'b1, addr: 12'(i)};
      @(negedge clock);
      expect_eq(32'(fetch_rsp.rvalid), 32'd1, "rvalid during back to back requests");
    end
    fetch_req = '{req: 1'b0, addr: 12'd0};
    @(negedge clock);
    expect_eq(32'(fetch_rsp.rvalid), 32'd0, "rvalid after back to back requests");
  endtask

  task automatic test_basic_program();
    apply_reset();
    sent_q.delete();
    load_words(8);
    send_terminator();
    for (int i = 0; i < 8; i++) begin
      read_word(12'(i), sent_q[i]);
    end
  endtask

  task automatic test_terminator();
    logic [31:0] a8;
    apply_reset();
    sent_q.delete();
    load_words(9);
    a8 = sent_q[8];
    send_terminator();
    apply_reset();
    expect_eq(32'(core_reset), 32'd1, "core reset high again after reset");
    sent_q.delete();
    load_words(8);
    send_terminator();
    // word after the terminator must be ignored
    send_word(next_rand());
    expect_eq(32'(core_reset), 32'd0, "core reset stays low after release");
    read_word(12'd8, a8);
    for (int i = 0; i < 8; i++) begin
      read_word(12'(i), sent_q[i]);
    end
  endtask

  task automatic test_framing_error();
    apply_reset();
    sent_q.delete();
    load_words(2);
    send_byte(8'hA5, 1'b1);
    load_words(3);
    send_terminator();
    for (int i = 0; i < 5; i++) begin
      read_word(12'(i), sent_q[i]);
    end
  endtask

  task automatic test_reset_mid_word();
    apply_reset();
    send_byte(8'h3C, 1'b0);
    send_byte(8'hC3, 1'b0);
    apply_reset();
    expect_eq(32'(core_reset), 32'd1, "core reset high after mid-word reset");
    sent_q.delete();
    load_words(3);
    send_terminator();
    for (int i = 0; i < 3; i++) begin
      read_word(12'(i), sent_q[i]);
    end
  endtask

  initial begin
    reset       = 1'b1;
    uart_rx     = 1'b1;
    fetch_req   = '{req: 1'b0, addr: 12'd0};
    error_count = 0;
    check_count = 0;
    rng_state   = 32'd30;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    test_reset_and_fetch();
    test_basic_program();
    test_terminator();
    test_framing_error();
    test_reset_mid_word();
    $display("checks run %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
source/boot_pkg.sv
source/uart_rx.sv
source/iccm_controller.sv
source/instr_mem.sv
source/iccm_boot_top.sv
testbench/iccm_boot_assertions.sv
testbench/tb_iccm_boot.sv
